// File: Makefile
TOP  := tb_rvv_coproc
LOG  := sim.log
SRCS := $(wildcard hw/*.sv tb/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
hw/rvv_pkg.sv
hw/rvv_vreg_if.sv
hw/rvv_mem_cmd_if.sv
hw/rvv_decoder.sv
hw/rvv_config.sv
hw/rvv_vregfile.sv
hw/rvv_mem_unit.sv
hw/rvv_sequencer.sv
hw/rvv_coproc_top.sv
tb/rvv_coproc_chk.sv
tb/tb_rvv_coproc.sv

// File: hw/rvv_config.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_config #(
	parameter int VLEN = 128
) (
	input  wire logic                     clk,
	input  wire logic                     resetn,
	input  wire logic                     update_i,
	input  wire rvv_pkg::rvv_op_e         op_i,
	input  wire logic [rvv_pkg::XLEN-1:0] insn_i,
	input  wire logic [rvv_pkg::XLEN-1:0] rs1_i,
	input  wire logic [rvv_pkg::XLEN-1:0] rs2_i,
	output logic [rvv_pkg::XLEN-1:0]      vl_o,
	output rvv_pkg::vtype_t               vtype_o
);
	import rvv_pkg::*;

	localparam logic [XLEN-1:0] VLEN_W = XLEN'(VLEN);

	vtype_t          vtype_q;
	vtype_t          vtype_new;
	logic [7:0]      zimm;
	logic [XLEN-1:0] vl_q;
	logic [XLEN-1:0] vlmax;
	logic [XLEN-1:0] avl;
	logic [XLEN-1:0] vl_new;
	logic            sew_ok;
	logic            illegal;

	// vsetvl takes vtype from rs2, the others from the immediate
	assign zimm      = (op_i == OP_VSETVL) ? rs2_i[7:0] : insn_i[27:20];
	assign vtype_new = vtype_t'({{(XLEN-8){1'b0}}, zimm});

	assign sew_ok = (vtype_new.vsew == SEW_8) || (vtype_new.vsew == SEW_16) ||
		(vtype_new.vsew == SEW_32);

	always_comb begin
		vlmax = VLEN_W >> (3 + int'(vtype_new.vsew)); // elements per register
		case (vtype_new.vlmul)
			3'd0, 3'd1, 3'd2, 3'd3: vlmax = vlmax << vtype_new.vlmul;
			3'd4:    vlmax = '0; // reserved lmul
			default: vlmax = vlmax >> (4'd8 - {1'b0, vtype_new.vlmul}); // mf8 to mf2
		endcase
	end

	assign illegal = !sew_ok || (vlmax == '0);

	always_comb begin
		if (op_i == OP_VSETIVLI)
			avl = XLEN'(insn_i[19:15]);
		else if (insn_i[19:15] != 5'd0)
			avl = rs1_i;
		else if (insn_i[11:7] != 5'd0)
			avl = '1; // ask for vlmax
		else
			avl = vl_q; // keep current vl
	end

	assign vl_new = (avl < vlmax) ? avl : vlmax;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vtype_q <= VTYPE_ILLEGAL;
			vl_q    <= '0;
		end else if (update_i) begin
			if (illegal) begin
				vtype_q <= VTYPE_ILLEGAL;
				vl_q    <= '0;
			end else begin
				vtype_q <= vtype_new;
				vl_q    <= vl_new;
			end
		end
	end

	assign vl_o    = vl_q;
	assign vtype_o = vtype_q;

endmodule

`default_nettype wire

// File: hw/rvv_coproc_top.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_coproc_top #(
	parameter int VLEN = 128
) (
	input  wire logic                     clk,
	input  wire logic                     resetn,
	input  wire logic                     pcpi_valid_i,
	input  wire logic [rvv_pkg::XLEN-1:0] pcpi_insn_i,
	input  wire logic [rvv_pkg::XLEN-1:0] pcpi_rs1_i,
	input  wire logic [rvv_pkg::XLEN-1:0] pcpi_rs2_i,
	output logic                          pcpi_wr_o,
	output logic [rvv_pkg::XLEN-1:0]      pcpi_rd_o,
	output logic                          pcpi_wait_o,
	output logic                          pcpi_ready_o,
	output logic                          pcpi_is_rvv_o,
	output logic                          wb_cyc_o,
	output logic                          wb_stb_o,
	output logic                          wb_we_o,
	output logic [rvv_pkg::XLEN-1:0]      wb_adr_o,
	output logic [rvv_pkg::XLEN-1:0]      wb_dat_o,
	output logic [3:0]                    wb_sel_o,
	input  wire logic [rvv_pkg::XLEN-1:0] wb_dat_i,
	input  wire logic                     wb_ack_i
);
	import rvv_pkg::*;

	rvv_op_e         op;
	rvv_sew_e        eew;
	logic            cfg_update;
	logic [XLEN-1:0] vl;
	vtype_t          vtype; // current vtype, observed from outside

	rvv_mem_cmd_if mem_cmd ();
	rvv_vreg_if #(.VLEN(VLEN)) vreg_bus ();

	rvv_decoder i_decoder (
		.insn_i   (pcpi_insn_i),
		.op_o     (op),
		.eew_o    (eew),
		.is_rvv_o (pcpi_is_rvv_o)
	);

	rvv_config #(.VLEN(VLEN)) i_config (
		.clk      (clk),
		.resetn   (resetn),
		.update_i (cfg_update),
		.op_i     (op),
		.insn_i   (pcpi_insn_i),
		.rs1_i    (pcpi_rs1_i),
		.rs2_i    (pcpi_rs2_i),
		.vl_o     (vl),
		.vtype_o  (vtype)
	);

	rvv_sequencer i_sequencer (
		.clk          (clk),
		.resetn       (resetn),
		.pcpi_valid_i (pcpi_valid_i),
		.pcpi_insn_i  (pcpi_insn_i),
		.pcpi_rs1_i   (pcpi_rs1_i),
		.pcpi_rs2_i   (pcpi_rs2_i),
		.op_i         (op),
		.eew_i        (eew),
		.vl_i         (vl),
		.cfg_update_o (cfg_update),
		.cmd          (mem_cmd.seq),
		.pcpi_wr_o    (pcpi_wr_o),
		.pcpi_rd_o    (pcpi_rd_o),
		.pcpi_wait_o  (pcpi_wait_o),
		.pcpi_ready_o (pcpi_ready_o)
	);

	rvv_mem_unit #(.VLEN(VLEN)) i_mem_unit (
		.clk      (clk),
		.resetn   (resetn),
		.cmd      (mem_cmd.unit),
		.vreg     (vreg_bus.master),
		.wb_cyc_o (wb_cyc_o),
		.wb_stb_o (wb_stb_o),
		.wb_we_o  (wb_we_o),
		.wb_adr_o (wb_adr_o),
		.wb_dat_o (wb_dat_o),
		.wb_sel_o (wb_sel_o),
		.wb_dat_i (wb_dat_i),
		.wb_ack_i (wb_ack_i)
	);

	rvv_vregfile #(.VLEN(VLEN)) i_vregfile (
		.clk  (clk),
		.vreg (vreg_bus.target)
	);

endmodule

`default_nettype wire

// File: hw/rvv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_decoder (
	input  wire logic [rvv_pkg::XLEN-1:0] insn_i,
	output rvv_pkg::rvv_op_e              op_o,
	output rvv_pkg::rvv_sew_e             eew_o,
	output logic                          is_rvv_o
);
	import rvv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       unit_stride;

	assign opcode = insn_i[6:0];
	assign funct3 = insn_i[14:12];

	// nf, mew, mop and lumop/sumop all zero, vm is don't care
	assign unit_stride = (insn_i[31:26] == 6'd0) && (insn_i[24:20] == 5'd0);

	always_comb begin
		op_o  = OP_NONE;
		eew_o = SEW_8;
		case (opcode)
			OPC_OP_V: begin
				if (funct3 == 3'b111) begin
					if (!insn_i[31])
						op_o = OP_VSETVLI;
					else if (insn_i[31:30] == 2'b11)
						op_o = OP_VSETIVLI;
					else if (insn_i[31:25] == 7'b1000000)
						op_o = OP_VSETVL;
				end
			end
			OPC_LOAD_FP, OPC_STORE_FP: begin
				case (funct3)
					3'b000:  eew_o = SEW_8;
					3'b101:  eew_o = SEW_16;
					3'b110:  eew_o = SEW_32;
					default: eew_o = SEW_RSVD; // e64 or scalar fp width
				endcase
				if (unit_stride && eew_o != SEW_RSVD)
					op_o = (opcode == OPC_STORE_FP) ? OP_VSE : OP_VLE;
			end
			default: op_o = OP_NONE;
		endcase
	end

	assign is_rvv_o = (op_o != OP_NONE);

endmodule

`default_nettype wire

// File: hw/rvv_mem_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rvv_mem_cmd_if;
	import rvv_pkg::*;

	logic            start;  // one cycle, unit idle
	logic            store;
	rvv_sew_e        eew;
	vreg_addr_t      vd;
	logic [XLEN-1:0] base;
	logic [XLEN-1:0] vl;
	logic            done;   // one cycle after last element

	modport seq (
		output start,
		output store,
		output eew,
		output vd,
		output base,
		output vl,
		input  done
	);

	modport unit (
		input  start,
		input  store,
		input  eew,
		input  vd,
		input  base,
		input  vl,
		output done
	);

endinterface

`default_nettype wire

// File: hw/rvv_mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_mem_unit #(
	parameter int VLEN = 128
) (
	input  wire logic                     clk,
	input  wire logic                     resetn,
	rvv_mem_cmd_if.unit                   cmd,
	rvv_vreg_if.master                    vreg,
	output logic                          wb_cyc_o,
	output logic                          wb_stb_o,
	output logic                          wb_we_o,
	output logic [rvv_pkg::XLEN-1:0]      wb_adr_o,
	output logic [rvv_pkg::XLEN-1:0]      wb_dat_o,
	output logic [3:0]                    wb_sel_o,
	input  wire logic [rvv_pkg::XLEN-1:0] wb_dat_i,
	input  wire logic                     wb_ack_i
);
	import rvv_pkg::*;

	localparam int VLENB = VLEN / 8;
	localparam int LB    = $clog2(VLENB); // log2 of bytes per register

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUS,
		ST_FINISH
	} state_e;

	state_e          state;
	logic            stb_q;
	logic [XLEN-1:0] cnt;       // element index
	logic [XLEN-1:0] grp_pos;   // byte position inside the register group
	logic [XLEN-1:0] byte_addr;
	logic [LB-1:0]   reg_off;
	vreg_addr_t      vidx;
	logic [1:0]      lane;      // byte lane in the bus word
	logic [3:0]      emask;
	logic [31:0]     st_elem;
	logic            last;
	logic            xfer;

	assign grp_pos   = cnt << cmd.eew;
	assign byte_addr = cmd.base + grp_pos;
	assign lane      = byte_addr[1:0];
	assign reg_off   = grp_pos[LB-1:0];
	assign vidx      = cmd.vd + vreg_addr_t'(grp_pos >> LB); // group can span registers
	assign last      = (cnt == cmd.vl - 1'b1);
	assign xfer      = stb_q && wb_ack_i;

	always_comb begin
		case (cmd.eew)
			SEW_16:  emask = 4'b0011;
			SEW_32:  emask = 4'b1111;
			default: emask = 4'b0001;
		endcase
	end

	// element must not cross a word boundary
	assign wb_cyc_o = stb_q;
	assign wb_stb_o = stb_q;
	assign wb_we_o  = stb_q & cmd.store;
	assign wb_adr_o = {byte_addr[XLEN-1:2], 2'b00};
	assign wb_sel_o = emask << lane;
	assign st_elem  = 32'(vreg.rdata >> {reg_off, 3'b000});
	assign wb_dat_o = st_elem << {lane, 3'b000};

	// load data lands at the element's byte offset in the register
	assign vreg.we    = xfer && !cmd.store;
	assign vreg.waddr = vidx;
	assign vreg.raddr = vidx;
	assign vreg.wbe   = VLENB'(emask) << reg_off;
	assign vreg.wdata = VLEN'(wb_dat_i >> {lane, 3'b000}) << {reg_off, 3'b000};

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ST_IDLE;
			stb_q <= 1'b0;
			cnt   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					cnt <= '0;
					if (cmd.start) begin
						if (cmd.vl == '0) begin
							state <= ST_FINISH; // nothing to move
						end else begin
							state <= ST_BUS;
							stb_q <= 1'b1;
						end
					end
				end
				ST_BUS: begin
					if (xfer) begin
						stb_q <= 1'b0; // bus cycle ends, idle one clock
						if (last)
							state <= ST_FINISH;
						else
							cnt <= cnt + 1'b1;
					end else if (!stb_q) begin
						stb_q <= 1'b1; // next element
					end
				end
				ST_FINISH: state <= ST_IDLE;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	assign cmd.done = (state == ST_FINISH);

endmodule

`default_nettype wire

// File: hw/rvv_pkg.sv
`default_nettype none

package rvv_pkg;

	localparam int XLEN      = 32;
	localparam int NUM_VREGS = 32;

	typedef logic [4:0] vreg_addr_t;

	// major opcodes
	localparam logic [6:0] OPC_OP_V     = 7'b1010111;
	localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
	localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_VSETVLI,
		OP_VSETIVLI,
		OP_VSETVL,
		OP_VLE,
		OP_VSE
	} rvv_op_e;

	// same encoding as the vsew field of vtype
	typedef enum logic [2:0] {
		SEW_8    = 3'b000,
		SEW_16   = 3'b001,
		SEW_32   = 3'b010,
		SEW_RSVD = 3'b011
	} rvv_sew_e;

	typedef struct packed {
		logic             vill;
		logic [XLEN-10:0] rsvd;
		logic             vma;
		logic             vta;
		rvv_sew_e         vsew;
		logic [2:0]       vlmul;
	} vtype_t;

	localparam vtype_t VTYPE_ILLEGAL = vtype_t'({1'b1, {(XLEN-1){1'b0}}});

endpackage

`default_nettype wire

// File: hw/rvv_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_sequencer (
	input  wire logic                     clk,
	input  wire logic                     resetn,
	input  wire logic                     pcpi_valid_i,
	input  wire logic [rvv_pkg::XLEN-1:0] pcpi_insn_i,
	input  wire logic [rvv_pkg::XLEN-1:0] pcpi_rs1_i,
	input  wire logic [rvv_pkg::XLEN-1:0] pcpi_rs2_i,
	input  wire rvv_pkg::rvv_op_e         op_i,
	input  wire rvv_pkg::rvv_sew_e        eew_i,
	input  wire logic [rvv_pkg::XLEN-1:0] vl_i,
	output logic                          cfg_update_o,
	rvv_mem_cmd_if.seq                    cmd,
	output logic                          pcpi_wr_o,
	output logic [rvv_pkg::XLEN-1:0]      pcpi_rd_o,
	output logic                          pcpi_wait_o,
	output logic                          pcpi_ready_o
);
	import rvv_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_MEM_BUSY,
		S_RESPOND
	} state_e;

	state_e          state;
	logic            is_cfg;
	logic            is_mem;
	logic            dispatch;
	logic            cfg_q;     // answer carries vl
	logic            start_q;
	logic            store_q;
	rvv_sew_e        eew_q;
	vreg_addr_t      vd_q;
	logic [XLEN-1:0] base_q;
	logic [XLEN-1:0] vl_q;

	assign is_cfg   = (op_i == OP_VSETVLI) || (op_i == OP_VSETIVLI) || (op_i == OP_VSETVL);
	assign is_mem   = (op_i == OP_VLE) || (op_i == OP_VSE);
	assign dispatch = (state == S_IDLE) && pcpi_valid_i;

	assign cfg_update_o = dispatch && is_cfg;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state   <= S_IDLE;
			cfg_q   <= 1'b0;
			start_q <= 1'b0;
		end else begin
			start_q <= 1'b0;
			case (state)
				S_IDLE: begin
					if (dispatch && is_cfg) begin
						state <= S_RESPOND;
						cfg_q <= 1'b1;
					end else if (dispatch && is_mem) begin
						state   <= S_MEM_BUSY;
						cfg_q   <= 1'b0;
						start_q <= 1'b1;
					end
				end
				S_MEM_BUSY: if (cmd.done) state <= S_RESPOND;
				S_RESPOND:  state <= S_IDLE;
				default:    state <= S_IDLE;
			endcase
		end
	end

	// command fields, held while the unit works
	always_ff @(posedge clk) begin
		if (dispatch && is_mem) begin
			store_q <= (op_i == OP_VSE);
			eew_q   <= eew_i;
			vd_q    <= pcpi_insn_i[11:7];
			base_q  <= pcpi_rs1_i;
			vl_q    <= vl_i;
		end
	end

	assign cmd.start = start_q;
	assign cmd.store = store_q;
	assign cmd.eew   = eew_q;
	assign cmd.vd    = vd_q;
	assign cmd.base  = base_q;
	assign cmd.vl    = vl_q;

	assign pcpi_wait_o  = (state == S_MEM_BUSY);
	assign pcpi_ready_o = (state == S_RESPOND);
	assign pcpi_wr_o    = pcpi_ready_o && cfg_q;
	assign pcpi_rd_o    = pcpi_wr_o ? vl_i : '0; // vl already updated by config

endmodule

`default_nettype wire

// File: hw/rvv_vreg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rvv_vreg_if #(
	parameter int VLEN = 128
);
	import rvv_pkg::*;

	logic              we;
	vreg_addr_t        waddr;
	logic [VLEN/8-1:0] wbe;    // one bit per byte of the register
	logic [VLEN-1:0]   wdata;
	vreg_addr_t        raddr;
	logic [VLEN-1:0]   rdata;  // async read

	modport master (
		output we,
		output waddr,
		output wbe,
		output wdata,
		output raddr,
		input  rdata
	);

	modport target (
		input  we,
		input  waddr,
		input  wbe,
		input  wdata,
		input  raddr,
		output rdata
	);

endinterface

`default_nettype wire

// File: hw/rvv_vregfile.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_vregfile #(
	parameter int VLEN = 128
) (
	input wire logic   clk,
	rvv_vreg_if.target vreg
);
	import rvv_pkg::*;

	localparam int VLENB = VLEN / 8;

	logic [VLEN-1:0] regs [NUM_VREGS];

	initial begin
		for (int i = 0; i < NUM_VREGS; i++)
			regs[i] = '0;
	end

	// byte lanes, only the element being loaded is touched
	always_ff @(posedge clk) begin
		if (vreg.we) begin
			for (int b = 0; b < VLENB; b++) begin
				if (vreg.wbe[b])
					regs[vreg.waddr][8*b +: 8] <= vreg.wdata[8*b +: 8];
			end
		end
	end

	assign vreg.rdata = regs[vreg.raddr];

endmodule

`default_nettype wire

// File: tb/rvv_coproc_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_coproc_chk (
	input wire logic                     clk,
	input wire logic                     resetn,
	input wire logic                     pcpi_ready_i,
	input wire logic                     pcpi_wr_i,
	input wire logic                     wb_cyc_i,
	input wire logic                     wb_stb_i,
	input wire logic [rvv_pkg::XLEN-1:0] wb_adr_i,
	input wire logic                     wb_ack_i
);
	int unsigned fail_count = 0;

	// ready is a single pulse
	a_ready_pulse: assert property (@(posedge clk) disable iff (!resetn)
		pcpi_ready_i |=> !pcpi_ready_i)
	else begin
		fail_count++;
		$error("pcpi_ready_o stayed high for more than one cycle");
	end

	a_wr_with_ready: assert property (@(posedge clk) disable iff (!resetn)
		pcpi_wr_i |-> pcpi_ready_i)
	else begin
		fail_count++;
		$error("pcpi_wr_o high while pcpi_ready_o is low");
	end

	// strobe and address held until the slave answers
	a_stb_hold: assert property (@(posedge clk) disable iff (!resetn)
		wb_stb_i && !wb_ack_i |=> wb_stb_i && $stable(wb_adr_i))
	else begin
		fail_count++;
		$error("wb_stb_o dropped or wb_adr_o changed before wb_ack_i");
	end

	// one element per bus cycle
	a_cyc_end: assert property (@(posedge clk) disable iff (!resetn)
		wb_stb_i && wb_ack_i |=> !wb_cyc_i && !wb_stb_i)
	else begin
		fail_count++;
		$error("wb_cyc_o or wb_stb_o still high in the cycle after wb_ack_i");
	end

endmodule

bind rvv_coproc_top rvv_coproc_chk i_chk (
	.clk          (clk),
	.resetn       (resetn),
	.pcpi_ready_i (pcpi_ready_o),
	.pcpi_wr_i    (pcpi_wr_o),
	.wb_cyc_i     (wb_cyc_o),
	.wb_stb_i     (wb_stb_o),
	.wb_adr_i     (wb_adr_o),
	.wb_ack_i     (wb_ack_i)
);

`default_nettype wire

// File: tb/rvv_input.txt
// columns: op insn rs1 rs2 rd, all hex; rd is checked for configuration records only
// op: 0 unsupported, 1 vsetvli, 2 vsetivli, 3 vsetvl, 4 vle, 5 vse
1 000572d7 00000064 00000000 00000010 // vsetvli e8 m1, avl 100
1 00f572d7 00000002 00000000 00000002 // vsetvli e16 mf2, avl 2
1 012072d7 00000000 00000000 00000010 // vsetvli e32 m4, rs1 x0, vlmax
2 c11372d7 00000000 00000000 00000006 // vsetivli 6, e32 m2
3 80b572d7 00000100 00000008 00000008 // vsetvl e16 m1
1 014572d7 00000005 00000000 00000000 // lmul code 4
3 80b572d7 00000004 00000018 00000000 // reserved sew
4 02056087 00000000 00000000 00000000 // vle32 v1 with vl 0
1 011572d7 00000007 00000000 00000007 // vsetvli e32 m2, avl 7
4 02056107 00000040 00000000 00000000 // vle32 v2, 0x40
5 02056127 00000200 00000000 00000000 // vse32 v2, 0x200
1 000572d7 00000005 00000000 00000005 // vsetvli e8 m1, avl 5
4 02050207 00000081 00000000 00000000 // vle8 v4, 0x81
5 02050227 00000303 00000000 00000000 // vse8 v4, 0x303
1 008572d7 00000003 00000000 00000003 // vsetvli e16 m1, avl 3
4 02055307 000000a2 00000000 00000000 // vle16 v6, 0xa2
5 02055327 000003c6 00000000 00000000 // vse16 v6, 0x3c6
0 0ab56087 00000040 00000004 00000000 // vlse32, strided
0 00b502b3 00000001 00000002 00000000 // scalar add

// File: tb/tb_rvv_coproc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_coproc;
	import rvv_pkg::*;

	localparam int VLEN       = 128;
	localparam int VLENB      = VLEN / 8;
	localparam int MAX_REC    = 32;
	localparam int REC_WORDS  = 5;   // op, insn, rs1, rs2, rd
	localparam int MEM_WORDS  = 256;
	localparam int REC_CYCLES = 200;

	logic            clk;
	logic            resetn;
	logic            pcpi_valid;
	logic [XLEN-1:0] pcpi_insn;
	logic [XLEN-1:0] pcpi_rs1;
	logic [XLEN-1:0] pcpi_rs2;
	logic            pcpi_wr;
	logic [XLEN-1:0] pcpi_rd;
	logic            pcpi_wait;
	logic            pcpi_ready;
	logic            pcpi_is_rvv;
	logic            wb_cyc;
	logic            wb_stb;
	logic            wb_we;
	logic [XLEN-1:0] wb_adr;
	logic [XLEN-1:0] wb_dat_w;
	logic [3:0]      wb_sel;
	logic [XLEN-1:0] wb_dat_r = '0;
	logic            wb_ack = 1'b0;

	logic [31:0]     rec [MAX_REC*REC_WORDS];
	logic [31:0]     mem [MEM_WORDS];             // bus side memory
	logic [31:0]     exp_mem [MEM_WORDS];         // copy, updated by the reference model
	logic [7:0]      vbytes [NUM_VREGS*VLENB];    // reference register file, flat bytes
	int              num_rec;
	int              mismatches;
	int              other_errors;
	int              wait_left;
	int              seed = 32'h26bf_3779;
	logic [XLEN-1:0] cur_vl;

	rvv_coproc_top #(.VLEN(VLEN)) i_dut (
		.clk           (clk),
		.resetn        (resetn),
		.pcpi_valid_i  (pcpi_valid),
		.pcpi_insn_i   (pcpi_insn),
		.pcpi_rs1_i    (pcpi_rs1),
		.pcpi_rs2_i    (pcpi_rs2),
		.pcpi_wr_o     (pcpi_wr),
		.pcpi_rd_o     (pcpi_rd),
		.pcpi_wait_o   (pcpi_wait),
		.pcpi_ready_o  (pcpi_ready),
		.pcpi_is_rvv_o (pcpi_is_rvv),
		.wb_cyc_o      (wb_cyc),
		.wb_stb_o      (wb_stb),
		.wb_we_o       (wb_we),
		.wb_adr_o      (wb_adr),
		.wb_dat_o      (wb_dat_w),
		.wb_sel_o      (wb_sel),
		.wb_dat_i      (wb_dat_r),
		.wb_ack_i      (wb_ack)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// wishbone slave, 0 to 3 wait states before each ack
	always @(posedge clk) begin
		if (!resetn) begin
			wb_ack    <= 1'b0;
			wait_left <= 0;
		end else begin
			wb_ack <= 1'b0;
			if (wb_cyc && wb_stb && !wb_ack) begin
				if (wait_left == 0) begin
					wb_ack    <= 1'b1;
					wb_dat_r  <= mem[wb_adr[9:2]];
					wait_left <= $random(seed) & 32'd3;
					if (wb_we) begin
						for (int b = 0; b < 4; b++) begin
							if (wb_sel[b])
								mem[wb_adr[9:2]][8*b +: 8] <= wb_dat_w[8*b +: 8];
						end
					end
				end else begin
					wait_left <= wait_left - 1;
				end
			end
		end
	end

	task automatic check_word(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_op(input string name, input rvv_op_e got, input rvv_op_e exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// element size from the width field of a vector load/store
	function automatic int elem_bytes(input logic [2:0] width);
		case (width)
			3'b101:  return 2;
			3'b110:  return 4;
			default: return 1;
		endcase
	endfunction

	// byte-wise copy between expected memory and the reference registers
	task automatic update_model(input rvv_op_e op, input logic [XLEN-1:0] insn,
		input logic [XLEN-1:0] base);
		int              eb;
		int              vpos;
		logic [XLEN-1:0] addr;
		eb = elem_bytes(insn[14:12]);
		for (int k = 0; k < int'(cur_vl); k++) begin
			for (int j = 0; j < eb; j++) begin
				addr = base + XLEN'(k * eb + j);
				vpos = (int'(insn[11:7]) * VLENB + k * eb + j) % (NUM_VREGS * VLENB);
				if (op == OP_VLE)
					vbytes[vpos] = exp_mem[addr[9:2]][8*int'(addr[1:0]) +: 8];
				else
					exp_mem[addr[9:2]][8*int'(addr[1:0]) +: 8] = vbytes[vpos];
			end
		end
	endtask

	task automatic run_record(input int r);
		rvv_op_e         op;
		logic [XLEN-1:0] insn;
		logic [XLEN-1:0] rs1;
		logic [XLEN-1:0] rs2;
		logic [XLEN-1:0] exp_rd;
		int              cycles;
		logic            bad;
		op     = rvv_op_e'(rec[r*REC_WORDS][2:0]);
		insn   = rec[r*REC_WORDS+1];
		rs1    = rec[r*REC_WORDS+2];
		rs2    = rec[r*REC_WORDS+3];
		exp_rd = rec[r*REC_WORDS+4];
		@(posedge clk);
		pcpi_valid <= 1'b1;
		pcpi_insn  <= insn;
		pcpi_rs1   <= rs1;
		pcpi_rs2   <= rs2;
		@(negedge clk);
		check_op("decoded op", i_dut.op, op);
		check_word("pcpi_is_rvv_o", XLEN'(pcpi_is_rvv), XLEN'(op != OP_NONE));
		check_word("pcpi_ready_o", XLEN'(pcpi_ready), '0); // valid not yet sampled
		case (op)
			OP_VSETVLI, OP_VSETIVLI, OP_VSETVL: begin
				@(negedge clk);
				check_word("pcpi_ready_o", XLEN'(pcpi_ready), 1);
				check_word("pcpi_wr_o", XLEN'(pcpi_wr), 1);
				check_word("pcpi_rd_o", pcpi_rd, exp_rd);
				cur_vl = exp_rd;
			end
			OP_VLE, OP_VSE: begin
				cycles = 0;
				@(negedge clk);
				while (!pcpi_ready && cycles < REC_CYCLES) begin
					check_word("pcpi_wait_o", XLEN'(pcpi_wait), 1);
					@(negedge clk);
					cycles++;
				end
				if (!pcpi_ready) begin
					other_errors++;
					$display("record %0d: no pcpi_ready_o within %0d cycles", r, REC_CYCLES);
				end else begin
					check_word("pcpi_wr_o", XLEN'(pcpi_wr), '0);
					update_model(op, insn, rs1);
				end
			end
			default: begin
				bad = 1'b0;
				repeat (20) begin
					@(negedge clk);
					if (wb_cyc || pcpi_ready || pcpi_wait)
						bad = 1'b1;
				end
				if (bad) begin
					other_errors++;
					$display("record %0d: unsupported instruction got a response", r);
				end
			end
		endcase
		@(posedge clk);
		pcpi_valid <= 1'b0;
	endtask

	initial begin : main
		int total;
		resetn       = 1'b0;
		pcpi_valid   = 1'b0;
		pcpi_insn    = '0;
		pcpi_rs1     = '0;
		pcpi_rs2     = '0;
		mismatches   = 0;
		other_errors = 0;
		cur_vl       = '0;
		for (int i = 0; i < MAX_REC * REC_WORDS; i++)
			rec[i] = '1; // unread records end the list
		$readmemh("tb/rvv_input.txt", rec);
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i]     = $random(seed);
			exp_mem[i] = mem[i];
		end
		for (int i = 0; i < NUM_VREGS * VLENB; i++)
			vbytes[i] = '0;
		num_rec = 0;
		while (num_rec < MAX_REC && rec[num_rec*REC_WORDS] !== '1)
			num_rec++;
		if (num_rec == 0) begin
			other_errors++;
			$display("no records read from tb/rvv_input.txt");
		end

		repeat (3) @(posedge clk);
		resetn <= 1'b1;
		@(negedge clk);
		check_word("pcpi_ready_o", XLEN'(pcpi_ready), '0);
		check_word("pcpi_wr_o", XLEN'(pcpi_wr), '0);
		check_word("pcpi_wait_o", XLEN'(pcpi_wait), '0);
		check_word("wb_cyc_o", XLEN'(wb_cyc), '0);
		check_word("wb_stb_o", XLEN'(wb_stb), '0);
		check_word("wb_we_o", XLEN'(wb_we), '0);
		check_word("vtype", i_dut.vtype, 32'h8000_0000); // only vill
		check_word("vl", i_dut.vl, '0);

		for (int r = 0; r < num_rec; r++)
			run_record(r);

		// stored words must match, everything else untouched
		for (int i = 0; i < MEM_WORDS; i++)
			check_word($sformatf("mem[%0d]", i), mem[i], exp_mem[i]);

		total = mismatches + other_errors + int'(i_dut.i_chk.fail_count);
		$display("errors: %0d (mismatches %0d, other %0d, assertions %0d)", total,
			mismatches, other_errors, i_dut.i_chk.fail_count);
		if (total == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// run length scales with the number of records
	initial begin : watchdog
		wait (num_rec > 0);
		repeat (num_rec * REC_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles", num_rec * REC_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
